// ==== pointer_overlay_top.f ====
hw/pointer_pkg.sv
hw/vga_timing.sv
hw/cursor_draw.sv
hw/gloves_draw.sv
hw/gloves_rom.sv
hw/mouse_control.sv
hw/pointer_overlay_top.sv
verification/pointer_overlay_tb.sv

// ==== Bender.yml ====
package:
  name: pointer_overlay

sources:
  - files:
      - hw/pointer_pkg.sv
      - hw/vga_timing.sv
      - hw/cursor_draw.sv
      - hw/gloves_draw.sv
      - hw/gloves_rom.sv
      - hw/mouse_control.sv
      - hw/pointer_overlay_top.sv
  - target: test
    files:
      - verification/pointer_overlay_tb.sv

// ==== verification/pointer_overlay_tb.sv ====
/*
 * Testbench for the pointer overlay: six frames, three with the arrow cursor
 * and three with the gloves sprite. Position and game state change only while
 * bus_out is in vertical blanking. Every output word after reset is compared
 * with a raster and sprite model, and the run stops at the first mismatch.
 */

`timescale 1ns/1ps

module pointer_overlay_tb import pointer_pkg::*; ();

    localparam int timeout_cycles   = 2_600_000; // six frames of 420,000 cycles plus margin
    localparam int frame_count      = 6;
    localparam int first_valid_edge = 4;         // edges after reset before pixel (0,0) shows

    logic        clk;
    logic        rst;
    coord_t      xpos;
    coord_t      ypos;
    game_state_t game_state;
    vga_bus_t    bus_out;

    int     cycle_count = 0;
    int     reset_edges = 0;
    int     post_edges  = 0;
    int     cursor_hits = 0;
    int     keeper_hits = 0;
    coord_t exp_h       = '0;
    coord_t exp_v       = '0;

    pointer_overlay_top pointer_overlay_top_inst (
        .clk,
        .rst,
        .xpos,
        .ypos,
        .game_state,
        .bus_out
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string test_name, input logic [39:0] expected,
                                   input logic [39:0] actual);
        $display("** Error [%s]: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // first frame of each game state uses a fixed spot, the rest are random
    task automatic apply_frame(input int frame);
        game_state = (frame < 3) ? KICKER : KEEPER;
        if (frame % 3 == 0) begin
            xpos = 12'd100;
            ypos = 12'd60;
        end else begin
            xpos = coord_t'($urandom % 661);
            ypos = coord_t'($urandom % 501);
        end
    endtask

    task automatic wait_vblank(input logic level);
        do @(negedge clk); while (bus_out.vblnk !== level);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: six frames were not completed within %0d cycles",
                     timeout_cycles);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    always @(posedge clk) begin : check_output
        coord_t dx;
        coord_t dy;
        logic   blanked;
        logic   in_cursor;
        logic   in_gloves;
        logic [3:0] exp_flags;
        rgb_t   exp_rgb;

        dx        = bus_out.hcount - xpos; // wraps large when left of the sprite
        dy        = bus_out.vcount - ypos;
        blanked   = (bus_out.hcount >= 12'd640) || (bus_out.vcount >= 12'd480);
        in_cursor = (dx < 12'd16) && (dy < 12'd16) && (dx <= dy);
        in_gloves = (dx < 12'd32) && (dy < 12'd32);
        exp_flags = {(bus_out.hcount >= 12'd656) && (bus_out.hcount <= 12'd751),
                     bus_out.hcount >= 12'd640,
                     (bus_out.vcount >= 12'd490) && (bus_out.vcount <= 12'd491),
                     bus_out.vcount >= 12'd480};

        if (rst) begin
            if (reset_edges > 0) begin // the first edge still sees unreset registers
                assert (bus_out == '0) else report_mismatch("reset_state", 40'd0, bus_out);
            end
            reset_edges++;
            post_edges = 0;
        end else if (post_edges < first_valid_edge) begin
            // zero words from reset still flushing out of the pipeline
            assert (bus_out == '0) else report_mismatch("reset_state", 40'd0, bus_out);
            post_edges++;
        end else begin
            assert (bus_out.hcount == exp_h)
                else report_mismatch("raster_sequence", exp_h, bus_out.hcount);
            assert (bus_out.vcount == exp_v)
                else report_mismatch("raster_sequence", exp_v, bus_out.vcount);
            assert ({bus_out.hsync, bus_out.hblnk, bus_out.vsync, bus_out.vblnk} == exp_flags)
                else report_mismatch("sync_blank", exp_flags,
                                     {bus_out.hsync, bus_out.hblnk, bus_out.vsync,
                                      bus_out.vblnk});

            if (blanked) begin
                assert (bus_out.rgb == 12'h000)
                    else report_mismatch("background", 12'h000, bus_out.rgb);
            end else if (game_state == KICKER && in_cursor) begin
                assert (bus_out.rgb == 12'hfff)
                    else report_mismatch("cursor_mode", 12'hfff, bus_out.rgb);
                cursor_hits++;
            end else if (game_state == KEEPER && in_gloves) begin
                exp_rgb = {dy[4:1], dx[4:1], 4'h8}; // red from row, green from column
                assert (bus_out.rgb == exp_rgb)
                    else report_mismatch("keeper_mode", exp_rgb, bus_out.rgb);
                keeper_hits++;
            end else begin
                assert (bus_out.rgb == 12'h1a3)
                    else report_mismatch("background", 12'h1a3, bus_out.rgb);
            end

            if (exp_h == 12'd799) begin
                exp_h = '0;
                exp_v = (exp_v == 12'd524) ? 12'd0 : exp_v + 12'd1;
            end else begin
                exp_h = exp_h + 12'd1;
            end
        end
    end

    initial begin
        void'($urandom(32'h3de0c1bb));
        rst = 1'b1;
        apply_frame(0);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int f = 0; f < frame_count; f++) begin
            wait_vblank(1'b1); // visible part of frame f is done
            if (f < frame_count - 1) begin
                apply_frame(f + 1);
                wait_vblank(1'b0);
            end
        end

        if (cursor_hits == 0 || keeper_hits == 0) begin
            $display("no sprite pixel was checked in one of the game states");
            $display("TEST FAIL");
            $fatal(1);
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== hw/pointer_overlay_top.sv ====
/*
 * Pointer overlay top: raster generator followed by the mouse controller.
 * bus_out carries each pixel 3 cycles after it is generated.
 * xpos, ypos and game_state are plain levels, held stable over a frame.
 */

`timescale 1ns/1ps

module pointer_overlay_top import pointer_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  coord_t      xpos,
    input  coord_t      ypos,
    input  game_state_t game_state,
    output vga_bus_t    bus_out
);

    vga_bus_t bus_bg; // background raster

    vga_timing u_vga_timing (
        .clk,
        .rst,
        .bus (bus_bg)
    );

    mouse_control u_mouse_control (
        .clk,
        .rst,
        .xpos,
        .ypos,
        .game_state,
        .bus_in  (bus_bg),
        .bus_out
    );

endmodule

// ==== hw/mouse_control.sv ====
/*
 * Pointer controller: cursor and gloves drawers run side by side and the
 * game state picks one stream, then the choice is registered.
 * Latency from bus_in to bus_out is 3 cycles. game_state is not synchronised
 * and should only change during vertical blanking.
 */

`timescale 1ns/1ps

module mouse_control import pointer_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  coord_t      xpos,
    input  coord_t      ypos,
    input  game_state_t game_state,
    input  vga_bus_t    bus_in,
    output vga_bus_t    bus_out
);

    vga_bus_t     bus_cursor;
    vga_bus_t     bus_gloves;
    vga_bus_t     bus_sel;
    gloves_addr_t gloves_addr;
    rgb_t         gloves_rgb;

    cursor_draw u_cursor_draw (
        .clk,
        .rst,
        .bus_in,
        .xpos,
        .ypos,
        .bus_out (bus_cursor)
    );

    gloves_draw u_gloves_draw (
        .clk,
        .rst,
        .bus_in,
        .xpos,
        .ypos,
        .pixel_addr (gloves_addr),
        .rgb_pixel  (gloves_rgb),
        .bus_out    (bus_gloves)
    );

    gloves_rom u_gloves_rom (
        .clk,
        .addr (gloves_addr),
        .dout (gloves_rgb)
    );

    // both drawers have equal latency, so switching never mixes timings
    assign bus_sel = (game_state == KEEPER) ? bus_gloves : bus_cursor;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end else begin
            bus_out <= bus_sel;
        end
    end

endmodule

// ==== hw/gloves_rom.sv ====
/*
 * 1024x12 gloves image ROM with registered read, one cycle of latency.
 * Contents come from gloves_pixel at elaboration; there is no reset.
 */

`timescale 1ns/1ps

module gloves_rom import pointer_pkg::*; (
    input  logic         clk,
    input  gloves_addr_t addr,
    output rgb_t         dout
);

    rgb_t mem [gloves_depth];

    initial begin
        for (int i = 0; i < gloves_depth; i++) begin
            mem[i] = gloves_pixel(gloves_addr_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        dout <= mem[addr]; // block RAM style read
    end

endmodule

// ==== hw/gloves_draw.sv ====
/*
 * Gloves sprite overlay, 2 cycles from bus_in to bus_out.
 * Expects a ROM with one cycle of registered read latency on rgb_pixel.
 * The 32x32 image is opaque and clips where it runs into blanking.
 */

`timescale 1ns/1ps

module gloves_draw import pointer_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  vga_bus_t     bus_in,
    input  coord_t       xpos,
    input  coord_t       ypos,
    output gloves_addr_t pixel_addr,
    input  rgb_t         rgb_pixel,
    output vga_bus_t     bus_out
);

    coord_t   dx;
    coord_t   dy;
    logic     hit;
    vga_bus_t bus_s1;
    logic     hit_s1;
    vga_bus_t bus_s2;
    logic     hit_s2;

    assign dx  = bus_in.hcount - xpos;
    assign dy  = bus_in.vcount - ypos;
    assign hit = (dx < gloves_size) && (dy < gloves_size)
                 && !bus_in.hblnk && !bus_in.vblnk;

    // stage 1: address is dy*32 + dx
    always_ff @(posedge clk) begin
        if (rst) begin
            bus_s1     <= '0;
            hit_s1     <= 1'b0;
            pixel_addr <= '0;
        end else begin
            bus_s1     <= bus_in;
            hit_s1     <= hit;
            pixel_addr <= {dy[4:0], dx[4:0]};
        end
    end

    // stage 2: ROM word for this pixel is valid alongside bus_s2
    always_ff @(posedge clk) begin
        if (rst) begin
            bus_s2 <= '0;
            hit_s2 <= 1'b0;
        end else begin
            bus_s2 <= bus_s1;
            hit_s2 <= hit_s1;
        end
    end

    always_comb begin
        bus_out     = bus_s2;
        bus_out.rgb = hit_s2 ? rgb_pixel : bus_s2.rgb; // background passes otherwise
    end

endmodule

// ==== hw/cursor_draw.sv ====
/*
 * Arrow cursor overlay, 2 cycles from bus_in to bus_out.
 * The arrow is the lower-left triangle of a 16x16 square with its tip at
 * xpos, ypos. Positions are sampled live and must hold over a frame.
 */

`timescale 1ns/1ps

module cursor_draw import pointer_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  vga_bus_t bus_in,
    input  coord_t   xpos,
    input  coord_t   ypos,
    output vga_bus_t bus_out
);

    coord_t   dx;
    coord_t   dy;
    logic     hit;
    vga_bus_t bus_s1;
    logic     hit_s1;

    // left or above the tip wraps to a large value and fails the size test
    assign dx  = bus_in.hcount - xpos;
    assign dy  = bus_in.vcount - ypos;
    assign hit = (dx < cursor_size) && (dy < cursor_size) && (dx <= dy)
                 && !bus_in.hblnk && !bus_in.vblnk;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_s1 <= '0;
            hit_s1 <= 1'b0;
        end else begin
            bus_s1 <= bus_in;
            hit_s1 <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end else begin
            bus_out     <= bus_s1;
            bus_out.rgb <= hit_s1 ? cursor_rgb : bus_s1.rgb;
        end
    end

endmodule

// ==== hw/vga_timing.sv ====
/*
 * Raster generator for 640x480 in an 800x525 frame, one pixel per clock.
 * The bus output is registered; the first valid pixel (0,0) leaves on the
 * first clock after reset is released. Visible pixels carry bg_rgb.
 */

`timescale 1ns/1ps

module vga_timing import pointer_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output vga_bus_t bus
);

    coord_t hcnt;
    coord_t vcnt;
    logic   h_last;
    logic   v_last;
    logic   visible;

    assign h_last  = (hcnt == h_total - 12'd1);
    assign v_last  = (vcnt == v_total - 12'd1);
    assign visible = (hcnt < h_active) && (vcnt < v_active);

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            if (h_last) begin
                hcnt <= '0;
                vcnt <= v_last ? '0 : vcnt + 12'd1; // next line, or new frame
            end else begin
                hcnt <= hcnt + 12'd1;
            end
        end
    end

    // bus is the registered view of the current counter pair
    always_ff @(posedge clk) begin
        if (rst) begin
            bus <= '0;
        end else begin
            bus.hcount <= hcnt;
            bus.vcount <= vcnt;
            bus.hsync  <= (hcnt >= h_sync_start) && (hcnt <= h_sync_end);
            bus.hblnk  <= (hcnt >= h_active);
            bus.vsync  <= (vcnt >= v_sync_start) && (vcnt <= v_sync_end);
            bus.vblnk  <= (vcnt >= v_active);
            bus.rgb    <= visible ? bg_rgb : 12'h000;
        end
    end

endmodule

// ==== hw/pointer_pkg.sv ====
/*
 * Shared constants, types and the video bus for the pointer overlay.
 * Raster is fixed at 640x480 in an 800x525 frame; sync pulses are active high.
 * The gloves image is generated by gloves_pixel, so no image file is needed.
 */

package pointer_pkg;

    typedef logic [11:0] coord_t;       // counter or screen position
    typedef logic [11:0] rgb_t;         // 4:4:4 colour
    typedef logic [9:0]  gloves_addr_t; // row in [9:5], column in [4:0]

    typedef enum logic {
        KICKER = 1'b0,
        KEEPER = 1'b1
    } game_state_t;

    localparam coord_t h_active     = 12'd640;
    localparam coord_t h_total      = 12'd800;
    localparam coord_t h_sync_start = 12'd656;
    localparam coord_t h_sync_end   = 12'd751; // inclusive
    localparam coord_t v_active     = 12'd480;
    localparam coord_t v_total      = 12'd525;
    localparam coord_t v_sync_start = 12'd490;
    localparam coord_t v_sync_end   = 12'd491; // inclusive

    localparam coord_t cursor_size  = 12'd16;
    localparam coord_t gloves_size  = 12'd32;
    localparam int     gloves_depth = 1024;

    localparam rgb_t bg_rgb     = 12'h1a3;
    localparam rgb_t cursor_rgb = 12'hfff;

    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   hblnk;
        logic   vsync;
        logic   vblnk;
        rgb_t   rgb;
    } vga_bus_t;

    // red follows the row, green the column, blue is constant
    function automatic rgb_t gloves_pixel(input gloves_addr_t addr);
        return {addr[9:6], addr[4:1], 4'h8};
    endfunction

endpackage
